/* Makefile */
# Verilator build and run for the streaming load unit

VERILATOR ?= verilator
TOP       ?= tb_load_unit
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
LINT_TOP  ?= load_unit

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

lint:
	$(VERILATOR) --lint-only -Wall -Ihdl hdl/mem_if_pkg.sv hdl/load_pkg.sv \
		hdl/prefetch_fifo.sv hdl/load_request.sv hdl/channel_writer.sv \
		hdl/load_unit.sv --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
+incdir+hdl
hdl/mem_if_pkg.sv
hdl/load_pkg.sv
hdl/prefetch_fifo.sv
hdl/load_request.sv
hdl/channel_writer.sv
hdl/load_unit.sv
tb/load_checker.sv
tb/tb_load_unit.sv

/* hdl/channel_writer.sv */
`timescale 1ns/1ps
`include "load_macros.svh"

module channel_writer
    import load_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       op_start,
    input  logic                       enable,
    input  logic [`LOG2_BUF_DEPTH-1:0] start_addr,
    input  logic                       we,
    input  t_line                      wdata,
    input  logic                       buf_almost_full,
    output t_buf_write                 buf_write,
    output logic                       almost_full
);

    logic                       enabled;
    logic [`LOG2_BUF_DEPTH-1:0] next_addr;

    logic                       wr_en;
    logic [`LOG2_BUF_DEPTH-1:0] wr_addr;
    t_line                      wr_data;

    // A disabled channel never holds the load back
    assign almost_full = enabled && buf_almost_full;

    // ******************************
    // Enable and address counter
    // ******************************
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            enabled <= 1'b0;
            next_addr <= '0;
            wr_en <= 1'b0;
        end
        else
        begin
            wr_en <= we && enabled;
            if (op_start)
            begin
                enabled <= enable;
                next_addr <= start_addr;
            end
            else if (we && enabled)
            begin
                // Wraps at the buffer depth
                next_addr <= next_addr + 1'b1;
            end
        end
    end

    // Write address and data follow the strobe by one cycle
    always_ff @(posedge clk)
    begin
        wr_addr <= next_addr;
        wr_data <= wdata;
    end

    assign buf_write = '{we: wr_en, addr: wr_addr, data: wr_data};

endmodule

/* hdl/load_macros.svh */
`ifndef LOAD_MACROS_SVH
`define LOAD_MACROS_SVH

// Data path sizes
`define LINE_WIDTH 64
`define ADDR_WIDTH 32

// Prefetch FIFO depth, also the credit limit for lines in flight
`define LOG2_PREFETCH_SIZE 4
`define PREFETCH_SIZE 16

// Local channel buffers
`define LOG2_BUF_DEPTH 6

`endif

/* hdl/load_pkg.sv */
`include "load_macros.svh"

package load_pkg;

    typedef logic [`LINE_WIDTH-1:0] t_line;

    typedef struct packed
    {
        logic [`ADDR_WIDTH-1:0]     base_addr;
        logic [`ADDR_WIDTH-1:0]     index_off0;
        logic [`ADDR_WIDTH-1:0]     index_off1;
        logic [`ADDR_WIDTH-1:0]     index_off2;
        logic [30:0]                length;
        logic                       multiline;
        logic [1:0]                 chan_enable;
        logic [`LOG2_BUF_DEPTH-1:0] chan_start0;
        logic [`LOG2_BUF_DEPTH-1:0] chan_start1;
    } t_load_cmd;

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_PREPROCESS,
        ST_READ,
        ST_DONE
    } t_load_state;

    typedef struct packed
    {
        logic                       we;
        logic [`LOG2_BUF_DEPTH-1:0] addr;
        t_line                      data;
    } t_buf_write;

endpackage

/* hdl/load_request.sv */
`timescale 1ns/1ps
`include "load_macros.svh"

module load_request
    import mem_if_pkg::*;
    import load_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         op_start,
    input  t_load_cmd                    cmd,
    input  logic [`LOG2_PREFETCH_SIZE:0] fifo_count,
    input  logic [31:0]                  num_received,
    input  logic                         rd_req_almost_full,
    output t_rd_req                      rd_req,
    output logic [30:0]                  length,
    output logic                         request_done
);

    // Room kept for the largest burst beyond one line
    localparam int BURST_RESERVE = 3;

    t_load_state state;

    logic [`ADDR_WIDTH-1:0] index_off [3];
    logic [1:0]             off_sel;
    logic [`ADDR_WIDTH-1:0] run_addr;
    logic                   multiline;

    logic [31:0] num_requested;
    logic [31:0] num_requested_plus2;
    logic [31:0] num_requested_plus4;
    logic [31:0] length_ext;

    // Lines issued on the last two edges, not yet seen by the credit pipeline
    logic [2:0] issued_lines;
    logic [2:0] issued_lines_d;

    logic [31:0]        in_flight;
    logic signed [31:0] free_count;
    logic signed [31:0] allowed_lines;
    logic signed [31:0] credit;
    logic               can_request;

    assign length_ext = {1'b0, length};
    assign request_done = (state == ST_DONE) || (state == ST_IDLE);

    // ******************************
    // Credit calculation
    // ******************************
    always_ff @(posedge clk)
    begin
        in_flight <= num_requested - num_received;
        free_count <= $signed(32'(`PREFETCH_SIZE)) - $signed(32'(fifo_count));
        allowed_lines <= free_count - $signed(in_flight) - BURST_RESERVE;
    end

    assign credit = allowed_lines - $signed(32'(issued_lines)) - $signed(32'(issued_lines_d));
    assign can_request = !rd_req_almost_full && (credit > 0);

    // ******************************
    // Request FSM
    // ******************************
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
            rd_req.valid <= 1'b0;
            off_sel <= 2'd0;
            num_requested <= 32'd0;
            num_requested_plus2 <= 32'd2;
            num_requested_plus4 <= 32'd4;
            issued_lines <= 3'd0;
            issued_lines_d <= 3'd0;
        end
        else
        begin
            rd_req.valid <= 1'b0;
            issued_lines <= 3'd0;
            issued_lines_d <= issued_lines;

            case (state)
                ST_IDLE:
                begin
                    if (op_start)
                    begin
                        index_off[0] <= cmd.index_off0;
                        index_off[1] <= cmd.index_off1;
                        index_off[2] <= cmd.index_off2;
                        run_addr <= cmd.base_addr;
                        length <= cmd.length;
                        multiline <= cmd.multiline;
                        off_sel <= 2'd0;
                        num_requested <= 32'd0;
                        num_requested_plus2 <= 32'd2;
                        num_requested_plus4 <= 32'd4;
                        // Nothing to fetch
                        if (cmd.length == '0)
                            state <= ST_DONE;
                        else
                            state <= ST_PREPROCESS;
                    end
                end

                ST_PREPROCESS:
                begin
                    // One index offset per cycle
                    run_addr <= run_addr + index_off[off_sel];
                    off_sel <= off_sel + 2'd1;
                    if (off_sel == 2'd2)
                        state <= ST_READ;
                end

                ST_READ:
                begin
                    if (can_request)
                    begin
                        rd_req.addr <= run_addr;
                        rd_req.tag <= num_requested[15:0];
                        if (multiline && (num_requested_plus4 < length_ext) &&
                            (run_addr[1:0] == 2'b00))
                        begin
                            rd_req.valid <= 1'b1;
                            rd_req.len <= BURST_4;
                            issued_lines <= 3'd4;
                            num_requested <= num_requested_plus4;
                            num_requested_plus2 <= num_requested_plus4 + 32'd2;
                            num_requested_plus4 <= num_requested_plus4 + 32'd4;
                            run_addr <= run_addr + 4;
                        end
                        else if (multiline && (num_requested_plus2 < length_ext) &&
                                 (run_addr[0] == 1'b0))
                        begin
                            rd_req.valid <= 1'b1;
                            rd_req.len <= BURST_2;
                            issued_lines <= 3'd2;
                            num_requested <= num_requested_plus2;
                            num_requested_plus2 <= num_requested_plus2 + 32'd2;
                            num_requested_plus4 <= num_requested_plus2 + 32'd4;
                            run_addr <= run_addr + 2;
                        end
                        else if (num_requested < length_ext)
                        begin
                            rd_req.valid <= 1'b1;
                            rd_req.len <= BURST_1;
                            issued_lines <= 3'd1;
                            num_requested <= num_requested + 32'd1;
                            num_requested_plus2 <= num_requested + 32'd3;
                            num_requested_plus4 <= num_requested + 32'd5;
                            run_addr <= run_addr + 1;
                        end
                    end

                    if (num_requested == length_ext)
                        state <= ST_DONE;
                end

                ST_DONE:
                begin
                    state <= ST_IDLE;
                end

                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* hdl/load_unit.sv */
`timescale 1ns/1ps
`include "load_macros.svh"

module load_unit
    import mem_if_pkg::*;
    import load_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       op_start,
    input  t_load_cmd  cmd,
    input  logic       rd_req_almost_full,
    input  t_rd_rsp    rd_rsp,
    input  logic [1:0] buf_almost_full,
    output t_rd_req    rd_req,
    output t_buf_write buf_write0,
    output t_buf_write buf_write1,
    output logic       op_done
);

    t_load_state recv_state;

    logic [30:0] length;
    logic        request_done;
    logic [31:0] num_received;

    logic                         fifo_we;
    logic                         fifo_re;
    t_line                        fifo_rdata;
    logic                         fifo_rvalid;
    logic                         fifo_empty;
    logic [`LOG2_PREFETCH_SIZE:0] fifo_count;

    logic       fan_we;
    t_line      fan_data;
    logic [1:0] chan_almost_full;

    // ******************************
    // Request side
    // ******************************
    load_request i_load_request (
        .clk,
        .reset,
        .op_start,
        .cmd,
        .fifo_count,
        .num_received,
        .rd_req_almost_full,
        .rd_req,
        .length,
        .request_done
    );

    // Responses land in the prefetch FIFO while a load is running
    assign fifo_we = rd_rsp.valid && (recv_state == ST_READ);

    prefetch_fifo i_prefetch_fifo (
        .clk,
        .reset,
        .we     (fifo_we),
        .wdata  (rd_rsp.data),
        .re     (fifo_re),
        .rdata  (fifo_rdata),
        .rvalid (fifo_rvalid),
        .empty  (fifo_empty),
        .count  (fifo_count)
    );

    // ******************************
    // Receive FSM
    // ******************************
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            recv_state <= ST_IDLE;
            fifo_re <= 1'b0;
            fan_we <= 1'b0;
            op_done <= 1'b0;
            num_received <= 32'd0;
        end
        else
        begin
            // Drain only while no enabled channel is near full
            fifo_re <= !fifo_empty && !(|chan_almost_full);
            fan_we <= 1'b0;
            op_done <= 1'b0;

            case (recv_state)
                ST_IDLE:
                begin
                    if (op_start)
                    begin
                        num_received <= 32'd0;
                        if (cmd.length == '0)
                            recv_state <= ST_DONE;
                        else
                            recv_state <= ST_READ;
                    end
                end

                ST_READ:
                begin
                    if (fifo_rvalid)
                    begin
                        fan_we <= 1'b1;
                        num_received <= num_received + 32'd1;
                        if ((num_received + 32'd1 == {1'b0, length}) && request_done)
                            recv_state <= ST_DONE;
                    end
                end

                ST_DONE:
                begin
                    op_done <= 1'b1;
                    recv_state <= ST_IDLE;
                end

                default:
                begin
                    recv_state <= ST_IDLE;
                end
            endcase
        end
    end

    // Fan-out data register, qualified by fan_we
    always_ff @(posedge clk)
    begin
        fan_data <= fifo_rdata;
    end

    // ******************************
    // Channel writers
    // ******************************
    channel_writer i_channel_writer0 (
        .clk,
        .reset,
        .op_start,
        .enable          (cmd.chan_enable[0]),
        .start_addr      (cmd.chan_start0),
        .we              (fan_we),
        .wdata           (fan_data),
        .buf_almost_full (buf_almost_full[0]),
        .buf_write       (buf_write0),
        .almost_full     (chan_almost_full[0])
    );

    channel_writer i_channel_writer1 (
        .clk,
        .reset,
        .op_start,
        .enable          (cmd.chan_enable[1]),
        .start_addr      (cmd.chan_start1),
        .we              (fan_we),
        .wdata           (fan_data),
        .buf_almost_full (buf_almost_full[1]),
        .buf_write       (buf_write1),
        .almost_full     (chan_almost_full[1])
    );

endmodule

/* hdl/mem_if_pkg.sv */
`include "load_macros.svh"

package mem_if_pkg;

    // Burst length code, same encoding as the host cache-line length field
    typedef enum logic [1:0]
    {
        BURST_1 = 2'b00,
        BURST_2 = 2'b01,
        BURST_4 = 2'b11
    } t_burst_len;

    // One valid cycle asks for len consecutive lines starting at addr
    typedef struct packed
    {
        logic                   valid;
        logic [`ADDR_WIDTH-1:0] addr;
        logic [15:0]            tag;
        t_burst_len             len;
    } t_rd_req;

    // One line per valid cycle, in request order
    typedef struct packed
    {
        logic                   valid;
        logic [`LINE_WIDTH-1:0] data;
    } t_rd_rsp;

endpackage

/* hdl/prefetch_fifo.sv */
`timescale 1ns/1ps
`include "load_macros.svh"

module prefetch_fifo
    import load_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         we,
    input  t_line                        wdata,
    input  logic                         re,
    output t_line                        rdata,
    output logic                         rvalid,
    output logic                         empty,
    output logic [`LOG2_PREFETCH_SIZE:0] count
);

    t_line mem [`PREFETCH_SIZE];

    logic [`LOG2_PREFETCH_SIZE-1:0] wr_ptr;
    logic [`LOG2_PREFETCH_SIZE-1:0] rd_ptr;
    logic full;
    logic do_write;
    logic do_read;

    assign empty = (count == '0);
    assign full = (count == (`LOG2_PREFETCH_SIZE+1)'(`PREFETCH_SIZE));

    // Reads on an empty FIFO are dropped
    assign do_read = re && !empty;
    assign do_write = we && !full;

    // ******************************
    // Pointers and occupancy
    // ******************************
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            rvalid <= 1'b0;
        end
        else
        begin
            rvalid <= do_read;
            if (do_write)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_read)
                rd_ptr <= rd_ptr + 1'b1;
            // Simultaneous write and read keeps the count
            if (do_write && !do_read)
                count <= count + 1'b1;
            else if (!do_write && do_read)
                count <= count - 1'b1;
        end
    end

    // Storage and registered read data
    always_ff @(posedge clk)
    begin
        if (do_write)
            mem[wr_ptr] <= wdata;
        if (do_read)
            rdata <= mem[rd_ptr];
    end

endmodule

/* tb/load_checker.sv */
`timescale 1ns/1ps
`include "load_macros.svh"

module load_checker
    import mem_if_pkg::*;
    import load_pkg::*;
#(
    parameter int TOTAL_LINES = 100
)
(
    input  logic       clk,
    input  logic       reset,
    input  logic       op_start,
    input  t_load_cmd  cmd,
    input  t_rd_req    rd_req,
    input  t_buf_write buf_write0,
    input  t_buf_write buf_write1,
    input  logic       op_done,
    input  t_line      exp_data0,
    input  t_line      exp_data1,
    output int         idx0,
    output int         idx1,
    output int         error_count,
    output int         check_count,
    output int         done_count,
    output logic       timeout
);

    localparam int LIMIT = 200 * TOTAL_LINES + 500;

    t_load_cmd  c;
    logic       active;
    int         req_count;
    int         cycle;
    int         start_cycle;
    logic [31:0] exp_addr;
    logic [`LOG2_BUF_DEPTH-1:0] exp_waddr0;
    logic [`LOG2_BUF_DEPTH-1:0] exp_waddr1;

    function automatic int burst_lines(input t_burst_len len);
        if (len == BURST_4)
            return 4;
        else if (len == BURST_2)
            return 2;
        return 1;
    endfunction

    // Burst rule against our own count of requested lines
    function automatic t_burst_len expect_len(input t_load_cmd lc, input int req,
                                              input logic [31:0] addr);
        int len;
        len = int'({1'b0, lc.length});
        if (lc.multiline && (req + 4 < len) && (addr[1:0] == 2'b00))
            return BURST_4;
        if (lc.multiline && (req + 2 < len) && !addr[0])
            return BURST_2;
        return BURST_1;
    endfunction

    function automatic int lines_for(input logic en, input t_load_cmd lc);
        return en ? int'({1'b0, lc.length}) : 0;
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("** Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic fail(input string what);
        error_count++;
        $display("%s", what);
    endtask

    // ******************************
    // Watch and compare
    // ******************************
    always @(posedge clk)
    begin
        if (reset)
        begin
            active = 1'b0;
            cycle = 0;
            idx0 <= 0;
            idx1 <= 0;
            error_count = 0;
            check_count = 0;
            done_count = 0;
            timeout <= 1'b0;
        end
        else
        begin
            cycle++;
            if (cycle > LIMIT)
                timeout <= 1'b1;
            if (op_start)
            begin
                c = cmd;
                active = 1'b1;
                req_count = 0;
                start_cycle = cycle;
                exp_addr = cmd.base_addr + cmd.index_off0 + cmd.index_off1 + cmd.index_off2;
                idx0 <= 0;
                idx1 <= 0;
            end
            if (rd_req.valid)
            begin
                if (!active)
                    fail("Read request issued while no load was running");
                compare("rd_req.addr", 64'(rd_req.addr), 64'(exp_addr));
                compare("rd_req.tag", 64'(rd_req.tag), 64'(req_count[15:0]));
                compare("rd_req.len", 64'(rd_req.len), 64'(expect_len(c, req_count, exp_addr)));
                req_count += burst_lines(rd_req.len);
                exp_addr += 32'(burst_lines(rd_req.len));
                if (req_count > int'({1'b0, c.length}))
                    fail("More lines requested than the load length");
            end
            // Lines in flight stay bounded by the prefetch depth
            if (c.chan_enable[0] && (req_count - idx0 > `PREFETCH_SIZE + 2))
                fail("Too many lines in flight ahead of channel 0");
            if (buf_write0.we)
            begin
                if (!c.chan_enable[0])
                    fail("Disabled channel 0 wrote to its buffer");
                // Buffer address wraps at the buffer depth
                exp_waddr0 = c.chan_start0 + idx0[`LOG2_BUF_DEPTH-1:0];
                compare("buf_write0.addr", 64'(buf_write0.addr), 64'(exp_waddr0));
                compare("buf_write0.data", buf_write0.data, exp_data0);
                idx0 <= idx0 + 1;
            end
            if (buf_write1.we)
            begin
                if (!c.chan_enable[1])
                    fail("Disabled channel 1 wrote to its buffer");
                exp_waddr1 = c.chan_start1 + idx1[`LOG2_BUF_DEPTH-1:0];
                compare("buf_write1.addr", 64'(buf_write1.addr), 64'(exp_waddr1));
                compare("buf_write1.data", buf_write1.data, exp_data1);
                idx1 <= idx1 + 1;
            end
            if (op_done)
            begin
                if (!active)
                    fail("op_done pulsed with no load running");
                if (c.length == '0)
                    compare("op_done delay", 64'(cycle - start_cycle), 64'd2);
                compare("lines requested", 64'(req_count), 64'(c.length));
                // The last buffer write shares its cycle with op_done
                compare("channel 0 writes", 64'(idx0 + int'(buf_write0.we)),
                        64'(lines_for(c.chan_enable[0], c)));
                compare("channel 1 writes", 64'(idx1 + int'(buf_write1.we)),
                        64'(lines_for(c.chan_enable[1], c)));
                active = 1'b0;
                done_count++;
            end
        end
    end

endmodule

/* tb/tb_load_unit.sv */
`timescale 1ns/1ps
`include "load_macros.svh"

module tb_load_unit
    import mem_if_pkg::*;
    import load_pkg::*;
();

    localparam int NUM_LOADS = 5;
    // Lines over all loads: 10 + 23 + 40 + 0 + 12
    localparam int TOTAL_LINES = 85;

    logic       clk;
    logic       reset;
    logic       op_start;
    t_load_cmd  cmd;
    logic       rd_req_almost_full;
    t_rd_rsp    rd_rsp;
    logic [1:0] buf_almost_full;
    t_rd_req    rd_req;
    t_buf_write buf_write0;
    t_buf_write buf_write1;
    logic       op_done;

    t_line exp_data0;
    t_line exp_data1;
    int    idx0;
    int    idx1;
    int    error_count;
    int    check_count;
    int    done_count;
    logic  timeout;

    logic        rand_mode;
    logic [1:0]  af_hold;
    logic [31:0] rand_state;
    logic [31:0] line_q[$];
    int          delay;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Address in the high half, its complement in the low half
    function automatic t_line mem_word(input logic [31:0] a);
        return {a, ~a};
    endfunction

    function automatic t_line expected_line(input t_load_cmd lc, input int i);
        return mem_word(lc.base_addr + lc.index_off0 + lc.index_off1 + lc.index_off2 + 32'(i));
    endfunction

    function automatic t_load_cmd make_cmd(input logic [31:0] base, input logic [31:0] off0,
                                           input logic [31:0] off1, input logic [31:0] off2,
                                           input int len, input logic multi, input logic [1:0] en,
                                           input logic [5:0] start0, input logic [5:0] start1);
        t_load_cmd lc;
        lc = '0;
        lc.base_addr = base;
        lc.index_off0 = off0;
        lc.index_off1 = off1;
        lc.index_off2 = off2;
        lc.length = 31'(len);
        lc.multiline = multi;
        lc.chan_enable = en;
        lc.chan_start0 = start0;
        lc.chan_start1 = start1;
        return lc;
    endfunction

    assign exp_data0 = expected_line(cmd, idx0);
    assign exp_data1 = expected_line(cmd, idx1);

    load_unit i_load_unit (.*);

    load_checker #(.TOTAL_LINES(TOTAL_LINES)) i_load_checker (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ******************************
    // Memory model and back-pressure
    // ******************************
    always @(posedge clk)
    begin
        if (rd_req.valid)
        begin
            for (int k = 0; k < ((rd_req.len == BURST_4) ? 4 : (rd_req.len == BURST_2) ? 2 : 1); k++)
                line_q.push_back(rd_req.addr + 32'(k));
        end
        rd_rsp.valid <= 1'b0;
        if ((line_q.size() > 0) && (delay == 0))
        begin
            rd_rsp.valid <= 1'b1;
            rd_rsp.data <= mem_word(line_q.pop_front());
            if (rand_mode)
            begin
                rand_state = lcg_next(rand_state);
                delay = int'(rand_state[23:16]) % 6;
            end
        end
        else if (delay > 0)
        begin
            delay--;
        end
        if (rand_mode)
        begin
            rand_state = lcg_next(rand_state);
            rd_req_almost_full <= (rand_state[17:16] == 2'b00);
            buf_almost_full <= {rand_state[21:20] == 2'b00, rand_state[25:24] == 2'b00};
        end
        else
        begin
            rd_req_almost_full <= 1'b0;
            buf_almost_full <= af_hold;
        end
    end

    task automatic run_load(input t_load_cmd lc);
        @(posedge clk);
        cmd <= lc;
        op_start <= 1'b1;
        @(posedge clk);
        op_start <= 1'b0;
        do
            @(posedge clk);
        while (!op_done);
        repeat (4) @(posedge clk);
    endtask

    always @(posedge clk)
    begin
        if (timeout)
        begin
            $display("Timeout after a load stalled, checks %0d, errors %0d",
                     check_count, error_count);
            $display("Test failures found");
            $finish;
        end
    end

    initial
    begin
        reset = 1'b1;
        op_start = 1'b0;
        cmd = '0;
        rd_rsp = '0;
        rd_req_almost_full = 1'b0;
        buf_almost_full = 2'b00;
        rand_mode = 1'b0;
        af_hold = 2'b00;
        rand_state = 32'd97;
        delay = 0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        run_load(make_cmd(32'd100, 32'd3, 32'd5, 32'd7, 10, 1'b0, 2'b11, 6'd5, 6'd60));
        // Start address 1003 is unaligned
        run_load(make_cmd(32'd1001, 32'd2, 32'd0, 32'd0, 23, 1'b1, 2'b11, 6'd0, 6'd17));
        rand_mode <= 1'b1;
        run_load(make_cmd(32'd50, 32'd1, 32'd0, 32'd0, 40, 1'b1, 2'b01, 6'd40, 6'd0));
        rand_mode <= 1'b0;
        run_load(make_cmd(32'd7, 32'd0, 32'd0, 32'd0, 0, 1'b1, 2'b11, 6'd0, 6'd0));
        // Channel 0 disabled but reporting almost full
        af_hold <= 2'b01;
        run_load(make_cmd(32'd300, 32'd4, 32'd4, 32'd4, 12, 1'b1, 2'b10, 6'd9, 6'd33));

        $display("Loads done %0d of %0d, checks %0d, errors %0d",
                 done_count, NUM_LOADS, check_count, error_count);
        if ((error_count == 0) && (done_count == NUM_LOADS))
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule
